// File: rtl/cop_pkg.sv
// Shared types, encoding fields and constants of the co-processor, imported by every RTL unit
`default_nettype none

package cop_pkg;

    typedef logic [31:0] cop_word_t;     // Data word
    typedef logic [31:0] cop_insn_t;     // Encoded instruction
    typedef logic [3:0]  cpr_addr_t;     // CPR index
    typedef logic [4:0]  gpr_addr_t;     // GPR index
    typedef logic [3:0]  cop_ben_t;      // Byte enables
    typedef logic [2:0]  cop_class_t;    // Instruction class
    typedef logic [3:0]  cop_subclass_t; // Instruction subclass
    typedef logic [2:0]  cop_pw_t;       // Pack width code
    typedef logic [2:0]  cop_result_t;   // Result code

    typedef enum logic [1:0] {
        IDLE,                            // Out of reset
        WAITING,                         // Ready for an instruction
        FINISHED                         // Response held for the CPU
    } seq_state_t;

    localparam logic [6:0] COP_OPCODE = 7'b0001011; // Custom-0 major opcode

    // Bit positions inside the encoding
    localparam int unsigned FLD_RD_LO     = 7;
    localparam int unsigned FLD_PW_LO     = 12;
    localparam int unsigned FLD_CRS1_LO   = 15;
    localparam int unsigned FLD_CRS2_LO   = 19;
    localparam int unsigned FLD_SCLASS_LO = 25;
    localparam int unsigned FLD_CLASS_LO  = 29;

    localparam cop_class_t CLASS_PACKED_ARITH = 3'd1;
    localparam cop_class_t CLASS_MOVE         = 3'd2;
    localparam cop_class_t CLASS_BITWISE      = 3'd3;
    localparam cop_class_t CLASS_RANDOM       = 3'd4;

    localparam cop_subclass_t SCLASS_ADD    = 4'd0; // Packed arithmetic
    localparam cop_subclass_t SCLASS_SUB    = 4'd1;
    localparam cop_subclass_t SCLASS_MV2GPR = 4'd0; // Moves
    localparam cop_subclass_t SCLASS_MV2COP = 4'd1;
    localparam cop_subclass_t SCLASS_AND    = 4'd0; // Bitwise
    localparam cop_subclass_t SCLASS_OR     = 4'd1;
    localparam cop_subclass_t SCLASS_XOR    = 4'd2;
    localparam cop_subclass_t SCLASS_SEED   = 4'd0; // Random unit
    localparam cop_subclass_t SCLASS_SAMPLE = 4'd1;

    localparam cop_pw_t PW_32 = 3'd0;    // One 32-bit lane
    localparam cop_pw_t PW_16 = 3'd1;
    localparam cop_pw_t PW_8  = 3'd2;
    localparam cop_pw_t PW_4  = 3'd3;
    localparam cop_pw_t PW_2  = 3'd4;    // Sixteen 2-bit lanes

    localparam cop_result_t RESULT_SUCCESS = 3'd0;
    localparam cop_result_t RESULT_BAD_INS = 3'd1;

    localparam cop_word_t COP_LFSR_TAPS       = 32'h8020_0003; // Galois feedback mask
    localparam cop_word_t COP_LFSR_RESET_SEED = 32'h6A09_E667; // Any nonzero start

endpackage

`default_nettype wire

// File: rtl/cop_fu_if.sv
// Dispatch bundle from the sequencer to one functional unit, result returned combinationally
`default_nettype none
`timescale 1ns/10ps

interface cop_fu_if;
    import cop_pkg::*;

    logic          ivalid;    // Accept cycle of a legal insn for this unit
    cop_class_t    cls;       // Decoded class
    cop_subclass_t subclass;  // Decoded subclass
    cop_pw_t       pw;        // Pack width code
    cop_word_t     crs1_data; // CPR source 1
    cop_word_t     crs2_data; // CPR source 2
    cop_word_t     gpr_rs1;   // GPR operand from the CPU
    cop_ben_t      rd_ben;    // CPR write byte enables, zero when idle
    cop_word_t     rd_wdata;  // CPR write data, zero when idle

    modport dispatch (
        output ivalid, cls, subclass, pw, crs1_data, crs2_data, gpr_rs1,
        input  rd_ben, rd_wdata
    );

    modport unit (
        input  ivalid, cls, subclass, pw, crs1_data, crs2_data, gpr_rs1,
        output rd_ben, rd_wdata
    );

endinterface

`default_nettype wire

// File: rtl/cop_idecode.sv
// Combinational field extraction and legality check of the CPU's encoded instruction
`default_nettype none
`timescale 1ns/10ps

module cop_idecode (
    input  cop_pkg::cop_insn_t     enc,       // Encoded instruction
    output logic                   exception, // Illegal instruction
    output cop_pkg::cop_class_t    cls,
    output cop_pkg::cop_subclass_t subclass,
    output cop_pkg::cop_pw_t       pw,
    output cop_pkg::cpr_addr_t     crs1,
    output cop_pkg::cpr_addr_t     crs2,
    output cop_pkg::cpr_addr_t     crd,
    output cop_pkg::gpr_addr_t     rd
);
    import cop_pkg::*;

    logic opcode_ok;                                // Custom opcode present
    logic insn_ok;                                  // Class/subclass/pw legal

    assign cls      = enc[FLD_CLASS_LO  +: 3];
    assign subclass = enc[FLD_SCLASS_LO +: 4];
    assign pw       = enc[FLD_PW_LO     +: 3];
    assign crs1     = enc[FLD_CRS1_LO   +: 4];
    assign crs2     = enc[FLD_CRS2_LO   +: 4];
    assign crd      = enc[FLD_RD_LO     +: 4];      // Low 4 bits of rd field
    assign rd       = enc[FLD_RD_LO     +: 5];

    assign opcode_ok = (enc[6:0] == COP_OPCODE);

    always_comb begin
        insn_ok = 1'b0;                             // Unknown class by default
        case (cls)
            CLASS_PACKED_ARITH: begin
                insn_ok = (subclass == SCLASS_ADD || subclass == SCLASS_SUB) &&
                          (pw <= PW_2);             // Codes 5..7 undefined
            end
            CLASS_MOVE: begin
                insn_ok = (subclass == SCLASS_MV2GPR || subclass == SCLASS_MV2COP);
            end
            CLASS_BITWISE: begin
                insn_ok = (subclass == SCLASS_AND || subclass == SCLASS_OR ||
                           subclass == SCLASS_XOR);
            end
            CLASS_RANDOM: begin
                insn_ok = (subclass == SCLASS_SEED || subclass == SCLASS_SAMPLE);
            end
            default: insn_ok = 1'b0;
        endcase
    end

    assign exception = !opcode_ok || !insn_ok;

endmodule

`default_nettype wire

// File: rtl/cop_cprs.sv
// Sixteen-word CPR file with two combinational read ports and one byte-enabled write port
`default_nettype none
`timescale 1ns/10ps

module cop_cprs (
    input  logic               g_clk,
    input  logic               g_resetn,
    input  cop_pkg::cpr_addr_t crs1_addr,  // Read port 1
    output cop_pkg::cop_word_t crs1_rdata,
    input  cop_pkg::cpr_addr_t crs2_addr,  // Read port 2
    output cop_pkg::cop_word_t crs2_rdata,
    input  cop_pkg::cop_ben_t  crd_ben,    // Write port, zero means no write
    input  cop_pkg::cpr_addr_t crd_addr,
    input  cop_pkg::cop_word_t crd_wdata
);
    import cop_pkg::*;

    cop_word_t cprs [16];                  // Register storage

    assign crs1_rdata = cprs[crs1_addr];   // Asynchronous reads
    assign crs2_rdata = cprs[crs2_addr];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int r = 0; r < 16; r++) begin
                cprs[r] <= '0;
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (crd_ben[b]) begin      // Per-byte update
                    cprs[crd_addr][b*8 +: 8] <= crd_wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/cop_palu.sv
// Packed add/subtract, bitwise logic and GPR/CPR moves, fully combinational
`default_nettype none
`timescale 1ns/10ps

module cop_palu (
    cop_fu_if.unit port                     // Dispatch from the sequencer
);
    import cop_pkg::*;

    cop_word_t lane_start;                  // One at the low bit of each lane
    cop_word_t op_b;                        // crs2, inverted for subtract
    cop_word_t arith_res;                   // Packed add/sub result
    cop_word_t result;                      // Selected result before gating
    logic      is_sub;                      // Subtract
    logic      is_mv2gpr;                   // Result goes to a GPR only
    logic      carry;                       // Ripple carry inside a lane

    assign is_sub    = (port.subclass == SCLASS_SUB);
    assign is_mv2gpr = (port.cls == CLASS_MOVE) && (port.subclass == SCLASS_MV2GPR);
    assign op_b      = port.crs2_data ^ {32{is_sub}};

    always_comb begin
        case (port.pw)
            PW_32:   lane_start = 32'h0000_0001;
            PW_16:   lane_start = 32'h0001_0001;
            PW_8:    lane_start = 32'h0101_0101;
            PW_4:    lane_start = 32'h1111_1111;
            PW_2:    lane_start = 32'h5555_5555;
            default: lane_start = 32'h0000_0001; // Rejected by the decoder
        endcase
    end

    // Carry chain restarts at every lane base, so nothing crosses lanes
    always_comb begin
        carry = is_sub;
        for (int i = 0; i < 32; i++) begin
            if (lane_start[i]) begin
                carry = is_sub;             // +1 of two's complement per lane
            end
            arith_res[i] = port.crs1_data[i] ^ op_b[i] ^ carry;
            carry = (port.crs1_data[i] & op_b[i]) |
                    (carry & (port.crs1_data[i] ^ op_b[i]));
        end
    end

    always_comb begin
        result = '0;
        case (port.cls)
            CLASS_PACKED_ARITH: result = arith_res;
            CLASS_MOVE: begin
                result = (port.subclass == SCLASS_MV2COP) ? port.gpr_rs1
                                                          : port.crs1_data;
            end
            CLASS_BITWISE: begin
                case (port.subclass)
                    SCLASS_AND: result = port.crs1_data & port.crs2_data;
                    SCLASS_OR:  result = port.crs1_data | port.crs2_data;
                    SCLASS_XOR: result = port.crs1_data ^ port.crs2_data;
                    default:    result = '0;
                endcase
            end
            default: result = '0;
        endcase
    end

    assign port.rd_wdata = port.ivalid ? result : '0;          // Zero when idle for OR merge
    assign port.rd_ben   = (port.ivalid && !is_mv2gpr) ? '1 : '0;

endmodule

`default_nettype wire

// File: rtl/cop_rng.sv
// Random number unit built on a 32-bit Galois LFSR, seeded and sampled by instruction
`default_nettype none
`timescale 1ns/10ps

module cop_rng (
    input  logic g_clk,
    input  logic g_resetn,
    cop_fu_if.unit port                         // Dispatch from the sequencer
);
    import cop_pkg::*;

    cop_word_t lfsr;                            // Current state
    cop_word_t lfsr_step;                       // State after one shift
    logic      do_seed;
    logic      do_sample;

    assign do_seed   = port.ivalid && (port.subclass == SCLASS_SEED);
    assign do_sample = port.ivalid && (port.subclass == SCLASS_SAMPLE);

    assign lfsr_step = (lfsr >> 1) ^ (lfsr[0] ? COP_LFSR_TAPS : '0);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            lfsr <= COP_LFSR_RESET_SEED;
        end else if (do_seed) begin
            lfsr <= (port.crs1_data != '0) ? port.crs1_data : COP_LFSR_RESET_SEED; // Never lock at zero
        end else if (do_sample) begin
            lfsr <= lfsr_step;
        end
    end

    assign port.rd_wdata = do_sample ? lfsr : '0;   // Sample returns the pre-step value
    assign port.rd_ben   = do_sample ? '1   : '0;   // Seed writes nothing

endmodule

`default_nettype wire

// File: rtl/cop_sequencer.sv
// CPU handshake FSM, dispatch to the units, CPR writeback merge and response registers
`default_nettype none
`timescale 1ns/10ps

module cop_sequencer (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  logic                   cpu_insn_req,  // CPU offers an instruction
    input  logic                   cpu_insn_ack,  // CPU takes the response
    input  cop_pkg::cop_word_t     cpu_rs1,
    input  logic                   exception,     // From the decoder
    input  cop_pkg::cop_class_t    cls,
    input  cop_pkg::cop_subclass_t subclass,
    input  cop_pkg::cop_pw_t       pw,
    input  cop_pkg::cpr_addr_t     crd,
    input  cop_pkg::gpr_addr_t     rd,
    input  cop_pkg::cop_word_t     crs1_rdata,
    input  cop_pkg::cop_word_t     crs2_rdata,
    output logic                   cop_insn_ack,
    output logic                   cop_insn_rsp,
    output logic                   cop_wen,
    output cop_pkg::gpr_addr_t     cop_waddr,
    output cop_pkg::cop_word_t     cop_wdata,
    output cop_pkg::cop_result_t   cop_result,
    output cop_pkg::cop_ben_t      crd_ben,       // CPR write port
    output cop_pkg::cpr_addr_t     crd_addr,
    output cop_pkg::cop_word_t     crd_wdata,
    cop_fu_if.dispatch             palu_port,
    cop_fu_if.dispatch             rng_port
);
    import cop_pkg::*;

    seq_state_t state, n_state;
    logic       n_ack, n_rsp;                     // Next handshake outputs
    logic       accept;                           // Instruction taken this cycle
    logic       retire;                           // Response taken this cycle

    assign accept = cpu_insn_req && cop_insn_ack;
    assign retire = cop_insn_rsp && cpu_insn_ack;

    // Dispatch, only in the accept cycle of a legal instruction
    assign palu_port.ivalid = accept && !exception && (cls == CLASS_PACKED_ARITH ||
                              cls == CLASS_MOVE || cls == CLASS_BITWISE);
    assign rng_port.ivalid  = accept && !exception && (cls == CLASS_RANDOM);

    assign palu_port.cls       = cls;
    assign palu_port.subclass  = subclass;
    assign palu_port.pw        = pw;
    assign palu_port.crs1_data = crs1_rdata;
    assign palu_port.crs2_data = crs2_rdata;
    assign palu_port.gpr_rs1   = cpu_rs1;
    assign rng_port.cls        = cls;
    assign rng_port.subclass   = subclass;
    assign rng_port.pw         = pw;
    assign rng_port.crs1_data  = crs1_rdata;
    assign rng_port.crs2_data  = crs2_rdata;
    assign rng_port.gpr_rs1    = cpu_rs1;

    assign crd_ben   = palu_port.rd_ben   | rng_port.rd_ben;   // Idle unit drives zero
    assign crd_wdata = palu_port.rd_wdata | rng_port.rd_wdata;
    assign crd_addr  = crd;

    always_comb begin
        n_state = state;
        n_ack   = 1'b0;
        n_rsp   = 1'b0;
        case (state)
            IDLE: begin
                n_state = WAITING;
                n_ack   = 1'b1;
            end
            WAITING: begin
                if (accept) begin                 // Both units finish at once
                    n_state = FINISHED;
                    n_rsp   = 1'b1;
                end else begin
                    n_ack   = 1'b1;
                end
            end
            FINISHED: begin
                if (retire) begin
                    n_state = WAITING;
                    n_ack   = 1'b1;
                end else begin
                    n_rsp   = 1'b1;               // Hold under back-pressure
                end
            end
            default: n_state = IDLE;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state        <= IDLE;
            cop_insn_ack <= 1'b0;
            cop_insn_rsp <= 1'b0;
            cop_wen      <= 1'b0;
            cop_result   <= RESULT_SUCCESS;
        end else begin
            state        <= n_state;
            cop_insn_ack <= n_ack;
            cop_insn_rsp <= n_rsp;
            if (accept) begin
                cop_wen    <= !exception && cls == CLASS_MOVE && subclass == SCLASS_MV2GPR;
                cop_result <= exception ? RESULT_BAD_INS : RESULT_SUCCESS;
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            cop_waddr <= rd;
            cop_wdata <= palu_port.rd_wdata;      // MV2GPR data
        end
    end

endmodule

`default_nettype wire

// File: rtl/cop_top.sv
// Co-processor top level, connecting decoder, CPR file, sequencer and units to the CPU port
`default_nettype none
`timescale 1ns/10ps

module cop_top (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  logic                 cpu_insn_req,
    input  logic                 cpu_insn_ack,
    input  cop_pkg::cop_insn_t   cpu_insn_enc,
    input  cop_pkg::cop_word_t   cpu_rs1,
    output logic                 cop_insn_ack,
    output logic                 cop_insn_rsp,
    output logic                 cop_wen,
    output cop_pkg::gpr_addr_t   cop_waddr,
    output cop_pkg::cop_word_t   cop_wdata,
    output cop_pkg::cop_result_t cop_result
);
    import cop_pkg::*;

    logic          id_exception;
    cop_class_t    id_cls;
    cop_subclass_t id_subclass;
    cop_pw_t       id_pw;
    cpr_addr_t     id_crs1, id_crs2, id_crd;
    gpr_addr_t     id_rd;
    cop_word_t     crs1_rdata, crs2_rdata;
    cop_ben_t      crd_ben;
    cpr_addr_t     crd_addr;
    cop_word_t     crd_wdata;

    cop_fu_if palu_if ();                 // Sequencer to packed ALU
    cop_fu_if rng_if ();                  // Sequencer to random unit

    cop_idecode idecode0 (
        .enc(cpu_insn_enc), .exception(id_exception), .cls(id_cls),
        .subclass(id_subclass), .pw(id_pw), .crs1(id_crs1), .crs2(id_crs2),
        .crd(id_crd), .rd(id_rd)
    );

    cop_cprs cprs0 (
        .g_clk(g_clk), .g_resetn(g_resetn),
        .crs1_addr(id_crs1), .crs1_rdata(crs1_rdata),
        .crs2_addr(id_crs2), .crs2_rdata(crs2_rdata),
        .crd_ben(crd_ben), .crd_addr(crd_addr), .crd_wdata(crd_wdata)
    );

    cop_sequencer sequencer0 (
        .g_clk(g_clk), .g_resetn(g_resetn),
        .cpu_insn_req(cpu_insn_req), .cpu_insn_ack(cpu_insn_ack), .cpu_rs1(cpu_rs1),
        .exception(id_exception), .cls(id_cls), .subclass(id_subclass), .pw(id_pw),
        .crd(id_crd), .rd(id_rd), .crs1_rdata(crs1_rdata), .crs2_rdata(crs2_rdata),
        .cop_insn_ack(cop_insn_ack), .cop_insn_rsp(cop_insn_rsp), .cop_wen(cop_wen),
        .cop_waddr(cop_waddr), .cop_wdata(cop_wdata), .cop_result(cop_result),
        .crd_ben(crd_ben), .crd_addr(crd_addr), .crd_wdata(crd_wdata),
        .palu_port(palu_if.dispatch), .rng_port(rng_if.dispatch)
    );

    cop_palu palu0 (
        .port(palu_if.unit)
    );

    cop_rng rng0 (
        .g_clk(g_clk), .g_resetn(g_resetn), .port(rng_if.unit)
    );

endmodule

`default_nettype wire

// File: sim/cop_checker.sv
// Handshake protocol assertions on the co-processor's CPU port, bound into cop_top
`default_nettype none
`timescale 1ns/10ps

module cop_checker (
    input logic                 g_clk,
    input logic                 g_resetn,
    input logic                 cpu_insn_req,
    input logic                 cpu_insn_ack,
    input logic                 cop_insn_ack,
    input logic                 cop_insn_rsp,
    input logic                 cop_wen,
    input cop_pkg::gpr_addr_t   cop_waddr,
    input cop_pkg::cop_word_t   cop_wdata,
    input cop_pkg::cop_result_t cop_result
);

    a_ack_rsp_exclusive: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(cop_insn_ack && cop_insn_rsp))
        else $error("cop_insn_ack and cop_insn_rsp high in the same cycle");

    a_quiet_after_reset: assert property (@(posedge g_clk)
        $rose(g_resetn) |-> (!cop_insn_ack && !cop_insn_rsp))
        else $error("Handshake outputs not low in the first cycle after reset");

    a_rsp_after_accept: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (cpu_insn_req && cop_insn_ack) |=> (cop_insn_rsp && !cop_insn_ack))
        else $error("No response one cycle after an accepted instruction");

    a_rsp_held: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (cop_insn_rsp && !cpu_insn_ack) |=> (cop_insn_rsp && $stable(cop_wen) &&
        $stable(cop_waddr) && $stable(cop_wdata) && $stable(cop_result)))
        else $error("Response changed while the CPU withheld its acknowledge");

endmodule

bind cop_top cop_checker checker0 (
    .g_clk(g_clk), .g_resetn(g_resetn),
    .cpu_insn_req(cpu_insn_req), .cpu_insn_ack(cpu_insn_ack),
    .cop_insn_ack(cop_insn_ack), .cop_insn_rsp(cop_insn_rsp),
    .cop_wen(cop_wen), .cop_waddr(cop_waddr),
    .cop_wdata(cop_wdata), .cop_result(cop_result)
);

`default_nettype wire

// File: sim/cop_tb.sv
// Testbench for cop_top that drives the CPU port and checks responses against a CPR and LFSR model
`default_nettype none
`timescale 1ns/10ps

module cop_tb;
    import cop_pkg::*;

    logic        g_clk, g_resetn, cpu_insn_req, cpu_insn_ack;
    cop_insn_t   cpu_insn_enc;
    cop_word_t   cpu_rs1;
    logic        cop_insn_ack, cop_insn_rsp, cop_wen;
    gpr_addr_t   cop_waddr;
    cop_word_t   cop_wdata;
    cop_result_t cop_result;

    cop_word_t cpr_model [16];                  // Shadow CPR file
    cop_word_t lfsr_model;                      // Shadow random unit state
    int        seed = 14114;
    int        wait_limit = 50;                 // Cycles per handshake wait

    cop_top dut0 (
        .g_clk(g_clk), .g_resetn(g_resetn), .cpu_insn_req(cpu_insn_req),
        .cpu_insn_ack(cpu_insn_ack), .cpu_insn_enc(cpu_insn_enc), .cpu_rs1(cpu_rs1),
        .cop_insn_ack(cop_insn_ack), .cop_insn_rsp(cop_insn_rsp), .cop_wen(cop_wen),
        .cop_waddr(cop_waddr), .cop_wdata(cop_wdata), .cop_result(cop_result)
    );

    initial begin
        g_clk = 1'b0;
        forever #50 g_clk = ~g_clk;             // 100 ns period
    end

    function automatic cop_insn_t encode(cop_class_t cls, cop_subclass_t sub, cop_pw_t pw,
                                         cpr_addr_t crs1, cpr_addr_t crs2, gpr_addr_t rd);
        return {cls, sub, 2'b00, crs2, crs1, pw, rd, COP_OPCODE};
    endfunction

    function automatic cop_word_t lfsr_next(cop_word_t s);
        cop_word_t n;
        logic      out_bit;
        out_bit = s[0];                         // Bit shifted out
        n       = {1'b0, s[31:1]};
        if (out_bit) begin
            n = n ^ COP_LFSR_TAPS;              // Galois feedback
        end
        return n;
    endfunction

    // Lane by lane arithmetic, result masked to the lane width
    function automatic cop_word_t packed_ref(cop_word_t a, cop_word_t b, logic sub, int pw);
        int              w;
        longint unsigned lmask, la, lb, lr;
        cop_word_t       r;
        w     = 32 >> pw;
        lmask = (64'h1 << w) - 64'h1;
        r     = '0;
        for (int l = 0; l < 32; l += w) begin
            la = (64'(a) >> l) & lmask;
            lb = (64'(b) >> l) & lmask;
            lr = sub ? la - lb : la + lb;       // Carry out of the lane is dropped
            r  = r | cop_word_t'((lr & lmask) << l);
        end
        return r;
    endfunction

    task automatic report_mismatch(string name, string what, cop_word_t exp, cop_word_t act);
        $display("[ERROR] %s: %s expected %h, actual %h", name, what, exp, act);
        $display("Checks failed");
        $fatal(1, "Response value mismatch");
    endtask

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "Protocol failure");
    endtask

    task automatic check_response(string name, logic exp_wen, gpr_addr_t exp_waddr,
                                  cop_word_t exp_wdata, cop_result_t exp_res);
        assert (cop_result == exp_res)
            else report_mismatch(name, "cop_result", 32'(exp_res), 32'(cop_result));
        assert (cop_wen == exp_wen)
            else report_mismatch(name, "cop_wen", 32'(exp_wen), 32'(cop_wen));
        assert (cop_waddr == exp_waddr)
            else report_mismatch(name, "cop_waddr", 32'(exp_waddr), 32'(cop_waddr));
        if (exp_wen) begin                      // Data only meaningful for MV2GPR
            assert (cop_wdata == exp_wdata)
                else report_mismatch(name, "cop_wdata", exp_wdata, cop_wdata);
        end
    endtask

    // Offer one instruction, await its response, hold it a random while, retire it
    task automatic run_insn(string name, cop_insn_t enc, cop_word_t rs1, logic exp_wen,
                            cop_word_t exp_wdata, cop_result_t exp_res);
        int t;
        int hold;
        cpu_insn_enc = enc;
        cpu_rs1      = rs1;
        cpu_insn_req = 1'b1;
        t = 0;
        while (!cop_insn_ack) begin
            @(posedge g_clk);
            #1;
            t++;
            if (t > wait_limit) report_failure("Timed out waiting for cop_insn_ack");
        end
        @(posedge g_clk);                       // Accept edge
        #1;
        cpu_insn_req = 1'b0;
        cpu_insn_enc = $random(seed);           // Bus is free once accepted
        t = 0;
        while (!cop_insn_rsp) begin
            @(posedge g_clk);
            #1;
            t++;
            if (t > wait_limit) report_failure("Timed out waiting for cop_insn_rsp");
        end
        check_response(name, exp_wen, enc[11:7], exp_wdata, exp_res);
        hold = {$random(seed)} % 6;
        for (int h = 0; h < hold; h++) begin
            cpu_insn_req = 1'b1;                // Try to push more work meanwhile
            @(posedge g_clk);
            #1;
            assert (cop_insn_rsp && !cop_insn_ack)
                else report_failure("Handshake changed while the response was held");
            check_response(name, exp_wen, enc[11:7], exp_wdata, exp_res);
        end
        cpu_insn_req = 1'b0;
        cpu_insn_ack = 1'b1;
        @(posedge g_clk);                       // Retire edge
        #1;
        cpu_insn_ack = 1'b0;
    endtask

    task automatic write_cpr(cpr_addr_t idx, cop_word_t val);
        run_insn("mv2cop", encode(CLASS_MOVE, SCLASS_MV2COP, PW_32, 4'd0, 4'd0, {1'b0, idx}),
                 val, 1'b0, '0, RESULT_SUCCESS);
        cpr_model[idx] = val;
    endtask

    task automatic read_cpr(string name, cpr_addr_t idx);
        gpr_addr_t rd;
        rd = gpr_addr_t'($random(seed));
        run_insn(name, encode(CLASS_MOVE, SCLASS_MV2GPR, PW_32, idx, 4'd0, rd),
                 $random(seed), 1'b1, cpr_model[idx], RESULT_SUCCESS);
    endtask

    task automatic sample_rng(string name, int count);
        cpr_addr_t d;
        for (int n = 0; n < count; n++) begin
            d = cpr_addr_t'($random(seed));
            run_insn(name, encode(CLASS_RANDOM, SCLASS_SAMPLE, PW_32, 4'd0, 4'd0, {1'b0, d}),
                     '0, 1'b0, '0, RESULT_SUCCESS);
            cpr_model[d] = lfsr_model;          // Pre-step value lands in the CPR
            lfsr_model   = lfsr_next(lfsr_model);
            read_cpr(name, d);
        end
    endtask

    task automatic seed_rng(string name, cop_word_t val);
        write_cpr(4'd3, val);
        run_insn(name, encode(CLASS_RANDOM, SCLASS_SEED, PW_32, 4'd3, 4'd0, 5'd0),
                 '0, 1'b0, '0, RESULT_SUCCESS);
        lfsr_model = (val != '0) ? val : COP_LFSR_RESET_SEED; // Zero falls back to reset seed
    endtask

    task automatic expect_illegal(string name, cop_insn_t enc);
        run_insn(name, enc, $random(seed), 1'b0, '0, RESULT_BAD_INS);
        read_cpr(name, 4'd7);                   // Target CPR must be untouched
    endtask

    initial begin
        cpr_addr_t a, b, d;
        cop_word_t expv;
        string     name;
        g_resetn     = 1'b0;
        cpu_insn_req = 1'b0;
        cpu_insn_ack = 1'b0;
        cpu_insn_enc = '0;
        cpu_rs1      = '0;
        for (int r = 0; r < 16; r++) cpr_model[r] = '0;
        lfsr_model = COP_LFSR_RESET_SEED;
        repeat (3) @(posedge g_clk);
        #1;
        g_resetn = 1'b1;

        for (int i = 0; i < 16; i++) write_cpr(cpr_addr_t'(i), $random(seed));
        for (int i = 0; i < 16; i++) read_cpr("mv2gpr", cpr_addr_t'(i));

        for (int pw = 0; pw <= 4; pw++) begin
            for (int s = 0; s < 4; s++) begin   // Two adds then two subtracts
                a    = cpr_addr_t'($random(seed));
                b    = cpr_addr_t'($random(seed));
                d    = cpr_addr_t'($random(seed));
                name = $sformatf("%s pw=%0d", (s >= 2) ? "psub" : "padd", pw);
                expv = packed_ref(cpr_model[a], cpr_model[b], s >= 2, pw);
                run_insn(name, encode(CLASS_PACKED_ARITH, (s >= 2) ? SCLASS_SUB : SCLASS_ADD,
                         cop_pw_t'(pw), a, b, {1'b0, d}), '0, 1'b0, '0, RESULT_SUCCESS);
                cpr_model[d] = expv;
                read_cpr(name, d);
            end
        end

        for (int op = 0; op < 3; op++) begin
            a    = cpr_addr_t'($random(seed));
            b    = cpr_addr_t'($random(seed));
            d    = cpr_addr_t'($random(seed));
            name = $sformatf("bitwise op=%0d", op);
            expv = (op == 0) ? (cpr_model[a] & cpr_model[b]) :
                   (op == 1) ? (cpr_model[a] | cpr_model[b]) : (cpr_model[a] ^ cpr_model[b]);
            run_insn(name, encode(CLASS_BITWISE, cop_subclass_t'(op), PW_32, a, b, {1'b0, d}),
                     '0, 1'b0, '0, RESULT_SUCCESS);
            cpr_model[d] = expv;
            read_cpr(name, d);
        end

        sample_rng("sample from reset", 2);
        seed_rng("seed value", 32'h1234_5678);
        sample_rng("sample after seed", 4);
        seed_rng("seed zero", 32'h0);
        sample_rng("sample after zero seed", 3);

        expect_illegal("bad opcode",
            (encode(CLASS_PACKED_ARITH, SCLASS_ADD, PW_32, 4'd1, 4'd2, 5'd7) & 32'hFFFF_FF80) |
            32'h0000_0033);                     // Register-register major opcode
        expect_illegal("bad class", encode(3'd0, 4'd0, PW_32, 4'd1, 4'd2, 5'd7));
        expect_illegal("bad class 7", encode(3'd7, 4'd0, PW_32, 4'd1, 4'd2, 5'd7));
        expect_illegal("bad pw", encode(CLASS_PACKED_ARITH, SCLASS_ADD, 3'd5, 4'd1, 4'd2, 5'd7));
        expect_illegal("bad subclass", encode(CLASS_BITWISE, 4'd3, PW_32, 4'd1, 4'd2, 5'd7));

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
rtl/cop_pkg.sv
rtl/cop_fu_if.sv
rtl/cop_idecode.sv
rtl/cop_cprs.sv
rtl/cop_palu.sv
rtl/cop_rng.sv
rtl/cop_sequencer.sv
rtl/cop_top.sv
sim/cop_checker.sv
sim/cop_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the co-processor simulation with Verilator, pass or fail from the log
set -u
cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

if ! verilator --binary --timing --assert --timescale 1ns/10ps \
        -f sim.f --top-module cop_tb -o cop_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cop_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ "$run_status" -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "All checks passed" sim.log; then
    exit 0
else
    echo "Pass message not found in sim.log"
    exit 1
fi
